//--- project.f
sram_pkg.sv
sram_cfg_regs.sv
sram_ctrl_fsm.sv
sram_pin_io.sv
sram_subsys_top.sv
sram_model.sv
sram_ctrl_checker.sv
tb_sram_subsys.sv

//--- tb_sram_subsys.sv
`timescale 1ns/100ps

module tb_sram_subsys;

  import sram_pkg::*;

  // chip timing in ns, inside the two-cycle minimum access window
  localparam real t_access = 15.0;
  localparam real t_hold   = 3.0;
  localparam real t_write  = 25.0;

  localparam logic [31:0] lfsr_seed = 32'h5bb91aaa;

  // access counts per test, they also size the watchdog
  localparam int n_pairs      = 16;
  localparam int n_fresh      = 8;
  localparam int n_mix        = 200;
  localparam int n_access     = 1 + 2 * n_pairs + n_fresh + 6 + 3 + n_mix;
  localparam int access_limit = 40;
  localparam int run_cycles   = 8 + n_access * 20 + 300;

  logic        oe_n;
  logic        rst;
  logic        req_valid;
  sram_req_t   req;
  logic        busy;
  logic        rsp_valid;
  sram_data_t  rdata;
  logic        cfg_wr;
  sram_cfg_t   cfg;
  logic        sram_ce_b;
  logic        sram_we_b;
  logic        sram_oe_b;
  sram_addr_t  sram_addr;
  wire sram_data_t sram_data;

  // reference memory image
  sram_data_t  shadow [0:(1<<sram_addr_w)-1];
  logic        written [0:(1<<sram_addr_w)-1];
  sram_data_t  exp_q [$];
  sram_cfg_t   eff_cfg;
  logic [31:0] lfsr;
  string       test_name;
  int          errors;
  int          checks;
  int          tests;
  int          test_start;

  sram_subsys_top i_dut (.*);

  sram_model #(
    .t_access (t_access),
    .t_hold   (t_hold),
    .t_write  (t_write)
  ) i_model (.*);

  initial begin
    oe_n = 1'b0;
    forever #5 oe_n = ~oe_n;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // last written word, else the zero-extended address
  function automatic sram_data_t ref_read(input sram_addr_t a);
    if (written[a]) begin
      return shadow[a];
    end
    return sram_data_t'(a);
  endfunction

  function automatic int total_errors();
    return errors + i_model.error_count + i_dut.i_ctrl_fsm.i_checker.fail_count;
  endfunction

  task automatic check_data(input string name, input sram_data_t exp, input sram_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input wait_t wait_val, input int extra,
                               input int act);
    checks++;
    if (act != int'(wait_val) + extra) begin
      errors++;
      $display("ERR %s latency: expected %0d actual %0d", name, int'(wait_val) + extra, act);
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %b actual %b", name, exp, act);
    end
  endtask

  // each response against the value queued at issue
  always @(negedge oe_n) begin
    if (rsp_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: response without an outstanding read", test_name);
      end else begin
        check_data(test_name, exp_q.pop_front(), rdata);
      end
    end
  end

  // cycles counted from the accepting edge
  // reads end on rsp_valid, writes on busy low
  task automatic run_access(input sram_req_t r, output int cycles);
    int  n;
    logic done;
    @(posedge oe_n);
    while (busy) @(posedge oe_n);
    req_valid <= 1'b1;
    req       <= r;
    @(posedge oe_n);
    req_valid <= 1'b0;
    n    = 0;
    done = 1'b0;
    while (!done && n < access_limit) begin
      @(negedge oe_n);
      done = r.write ? !busy : rsp_valid;
      if (!done) begin
        n++;
      end
    end
    if (!done) begin
      errors++;
      $display("%s: access to address %h never finished", test_name, r.addr);
    end
    cycles = n;
  endtask

  task automatic do_read(input sram_addr_t a);
    sram_req_t r;
    int cyc;
    r = '{write: 1'b0, addr: a, wdata: '0};
    exp_q.push_back(ref_read(a));
    run_access(r, cyc);
    check_latency(test_name, eff_cfg.read_wait, 3, cyc);
  endtask

  task automatic do_write(input sram_addr_t a, input sram_data_t d);
    sram_req_t r;
    int cyc;
    r = '{write: 1'b1, addr: a, wdata: d};
    shadow[a]  = d;
    written[a] = 1'b1;
    run_access(r, cyc);
    check_latency({test_name, " write"}, eff_cfg.write_wait, 5, cyc);
  endtask

  // zero waits are raised to one
  task automatic load_cfg(input wait_t rw, input wait_t ww);
    @(posedge oe_n);
    cfg_wr <= 1'b1;
    cfg    <= '{read_wait: rw, write_wait: ww};
    @(posedge oe_n);
    cfg_wr <= 1'b0;
    eff_cfg.read_wait  = (rw == 0) ? wait_t'(1) : rw;
    eff_cfg.write_wait = (ww == 0) ? wait_t'(1) : ww;
  endtask

  task automatic pulse_while_busy(input sram_req_t r);
    @(posedge oe_n);
    while (!busy) @(posedge oe_n);
    req_valid <= 1'b1;
    req       <= r;
    @(posedge oe_n);
    req_valid <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    test_start = total_errors();
  endtask

  task automatic end_test();
    @(posedge oe_n);
    tests++;
    $display("test %s done, %0d errors", test_name, total_errors() - test_start);
  endtask

  initial begin
    sram_addr_t a;
    sram_addr_t b;
    sram_addr_t addrs [$];
    int i;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    cfg_wr    = 1'b0;
    cfg       = '0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    lfsr      = lfsr_seed;
    eff_cfg.read_wait  = read_wait_rst;
    eff_cfg.write_wait = write_wait_rst;
    for (i = 0; i < (1<<sram_addr_w); i++) begin
      written[i] = 1'b0;
    end
    repeat (8) @(posedge oe_n);
    rst <= 1'b0;

    start_test("reset_state");
    @(negedge oe_n);
    check_level("reset_state sram_ce_b", 1'b1, sram_ce_b);
    check_level("reset_state sram_we_b", 1'b1, sram_we_b);
    check_level("reset_state sram_oe_b", 1'b1, sram_oe_b);
    check_level("reset_state busy", 1'b0, busy);
    check_level("reset_state rsp_valid", 1'b0, rsp_valid);
    if (sram_data !== 'z) begin
      errors++;
      $display("reset_state: data bus is driven after reset");
    end
    do_read(sram_addr_t'(take_bits(sram_addr_w)));
    end_test();

    start_test("write_read");
    for (i = 0; i < n_pairs; i++) begin
      a = sram_addr_t'(take_bits(sram_addr_w));
      addrs.push_back(a);
      do_write(a, sram_data_t'(take_bits(sram_data_w)));
    end
    foreach (addrs[j]) begin
      do_read(addrs[j]);
    end
    end_test();

    start_test("unwritten");
    for (i = 0; i < n_fresh; i++) begin
      do begin
        a = sram_addr_t'(take_bits(sram_addr_w));
      end while (written[a]);
      do_read(a);
    end
    end_test();

    start_test("wait_config");
    a = sram_addr_t'(take_bits(sram_addr_w));
    load_cfg(4'd5, 4'd3);
    do_read(a);
    do_write(a, sram_data_t'(take_bits(sram_data_w)));
    do_read(a);
    // zero behaves as one
    load_cfg(4'd0, 4'd0);
    do_read(a);
    do_write(a, sram_data_t'(take_bits(sram_data_w)));
    do_read(a);
    load_cfg(read_wait_rst, write_wait_rst);
    end_test();

    start_test("busy_ignore");
    a = sram_addr_t'(take_bits(sram_addr_w));
    b = a + 1'b1;
    fork
      do_read(a);
      pulse_while_busy('{write: 1'b1, addr: b, wdata: ~ref_read(b)});
    join
    do_read(b);
    end_test();

    start_test("random_mix");
    for (i = 0; i < n_mix; i++) begin
      if (i % 50 == 0) begin
        load_cfg(wait_t'(take_bits(2)), wait_t'(take_bits(2)));
      end
      a = sram_addr_t'(take_bits(sram_addr_w));
      if (take_bits(1) == 1) begin
        do_write(a, sram_data_t'(take_bits(sram_data_w)));
      end else begin
        do_read(a);
      end
    end
    end_test();

    $display("tests %0d, checks %0d, errors %0d (model %0d, assertions %0d)", tests, checks,
             total_errors(), i_model.error_count, i_dut.i_ctrl_fsm.i_checker.fail_count);
    if (total_errors() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog sized from the access count
  initial begin
    repeat (run_cycles) @(posedge oe_n);
    $display("timeout: run did not end within %0d cycles", run_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

//--- sram_ctrl_checker.sv
`timescale 1ns/100ps

module sram_ctrl_checker (
  input logic                  oe_n,
  input logic                  rst,
  input sram_pkg::ctrl_state_t state,
  input sram_pkg::sram_pins_t  pins_next,
  input logic                  rsp_valid
);

  import sram_pkg::*;

  int fail_count = 0;

  // read and write strobes never low in the same or in adjacent cycles
  // a direct handoff would overlap on the pins through flop skew
  strobe_overlap: assert property (
    @(posedge oe_n) disable iff (rst)
      (pins_next.we_b || pins_next.oe_b) &&
      ($past(pins_next.we_b) || pins_next.oe_b) &&
      ($past(pins_next.oe_b) || pins_next.we_b)
  ) else begin
    fail_count++;
    $error("oe_b and we_b requested low together or back to back");
  end

  rsp_one_cycle: assert property (
    @(posedge oe_n) disable iff (rst) rsp_valid |=> !rsp_valid
  ) else begin
    fail_count++;
    $error("rsp_valid high for more than one cycle");
  end

  // chip fully released while idle
  // the pins show what was requested one cycle earlier
  idle_pins: assert property (
    @(posedge oe_n) disable iff (rst) (state == idle) |->
      $past(pins_next.ce_b && pins_next.we_b && pins_next.oe_b && !pins_next.drive)
  ) else begin
    fail_count++;
    $error("pins active in idle");
  end

  addr_stable: assert property (
    @(posedge oe_n) disable iff (rst)
      (!pins_next.oe_b || !pins_next.we_b) |=> $stable(pins_next.addr)
  ) else begin
    fail_count++;
    $error("address moved while a strobe was low");
  end

endmodule

bind sram_ctrl_fsm sram_ctrl_checker i_checker (
  .oe_n      (oe_n),
  .rst       (rst),
  .state     (state),
  .pins_next (pins_next),
  .rsp_valid (rsp_valid)
);

//--- sram_model.sv
`timescale 1ns/100ps

module sram_model #(
  parameter real t_access = 1.0,
  parameter real t_hold   = 1.0,
  parameter real t_write  = 1.0
) (
  input  logic                 rst,
  input  logic                 sram_ce_b,
  input  logic                 sram_we_b,
  input  logic                 sram_oe_b,
  input  sram_pkg::sram_addr_t sram_addr,
  inout  sram_pkg::sram_data_t sram_data
);

  import sram_pkg::*;

  sram_data_t mem [0:(1<<sram_addr_w)-1];
  logic       written [0:(1<<sram_addr_w)-1];
  sram_data_t dout;
  logic       dout_en;
  logic       reading;
  // times of the last strobe fall, address change and data change
  realtime    strobe_time;
  realtime    addr_time;
  realtime    data_time;
  int         error_count;

  assign reading   = !sram_ce_b && !sram_oe_b && sram_we_b;
  assign sram_data = dout_en ? dout : 'z;

  // unwritten words read back as their own address
  function automatic sram_data_t word_at(input sram_addr_t a);
    if (written[a] === 1'b1) begin
      return mem[a];
    end
    return sram_data_t'(a);
  endfunction

  task automatic report_error(input string what);
    error_count++;
    $display("model error at %0.1f ns: %s", $realtime, what);
  endtask

  initial begin
    int i;
    error_count = 0;
    dout_en     = 1'b0;
    dout        = 'x;
    strobe_time = 0.0;
    addr_time   = 0.0;
    data_time   = 0.0;
    for (i = 0; i < (1<<sram_addr_w); i++) begin
      written[i] = 1'b0;
    end
  end

  // output invalid after the hold time, valid after the access time
  always @(reading or sram_addr) begin
    dout_en <= #(t_hold) reading;
    if (reading) begin
      dout <= #(t_hold) 'x;
      dout <= #(t_access) word_at(sram_addr);
    end
  end

  always @(negedge sram_oe_b or negedge sram_we_b) strobe_time = $realtime;
  always @(sram_addr) addr_time = $realtime;
  always @(sram_data) data_time = $realtime;

  // nobody else may drive the bus once oe_b is low
  always @(negedge sram_oe_b) begin
    #(t_hold / 2.0);
    if (rst === 1'b0 && sram_data !== 'z) begin
      report_error("data bus driven while oe_b fell");
    end
  end

  always @(posedge sram_oe_b) begin
    if (rst === 1'b0 && addr_time > strobe_time && addr_time < $realtime) begin
      report_error("address changed during a read");
    end
  end

  // write commits at the rising edge of we_b
  always @(posedge sram_we_b) begin
    if (rst === 1'b0 && sram_ce_b === 1'b0) begin
      if (addr_time > strobe_time && addr_time < $realtime) begin
        report_error("address changed during a write");
      end
      if (data_time > strobe_time && data_time < $realtime) begin
        report_error("data changed during a write");
      end
      if ($realtime - addr_time < t_write) begin
        report_error("write ended before the address setup time");
      end else begin
        mem[sram_addr]     = sram_data;
        written[sram_addr] = 1'b1;
      end
    end
  end

endmodule

//--- sram_subsys_top.sv
`timescale 1ns/100ps

module sram_subsys_top (
  input  logic                 oe_n,
  input  logic                 rst,
  input  logic                 req_valid,
  input  sram_pkg::sram_req_t  req,
  output logic                 busy,
  output logic                 rsp_valid,
  output sram_pkg::sram_data_t rdata,
  input  logic                 cfg_wr,
  input  sram_pkg::sram_cfg_t  cfg,
  output logic                 sram_ce_b,
  output logic                 sram_we_b,
  output logic                 sram_oe_b,
  output sram_pkg::sram_addr_t sram_addr,
  inout  sram_pkg::sram_data_t sram_data
);

  import sram_pkg::*;

  // held wait states
  sram_cfg_t  cfg_q;

  // controller to pin stage
  sram_pins_t pins_next;
  sram_data_t wdata_next;
  logic       capture;

  sram_cfg_regs i_cfg_regs (
    .oe_n   (oe_n),
    .rst    (rst),
    .cfg_wr (cfg_wr),
    .cfg    (cfg),
    .cfg_q  (cfg_q)
  );

  sram_ctrl_fsm i_ctrl_fsm (
    .oe_n       (oe_n),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .cfg_q      (cfg_q),
    .busy       (busy),
    .pins_next  (pins_next),
    .wdata_next (wdata_next),
    .capture    (capture),
    .rsp_valid  (rsp_valid)
  );

  sram_pin_io i_pin_io (
    .oe_n       (oe_n),
    .rst        (rst),
    .pins_next  (pins_next),
    .wdata_next (wdata_next),
    .capture    (capture),
    .sram_ce_b  (sram_ce_b),
    .sram_we_b  (sram_we_b),
    .sram_oe_b  (sram_oe_b),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .rdata      (rdata)
  );

endmodule

//--- sram_pin_io.sv
`timescale 1ns/100ps

module sram_pin_io (
  input  logic                 oe_n,
  input  logic                 rst,
  input  sram_pkg::sram_pins_t pins_next,
  input  sram_pkg::sram_data_t wdata_next,
  input  logic                 capture,
  output logic                 sram_ce_b,
  output logic                 sram_we_b,
  output logic                 sram_oe_b,
  output sram_pkg::sram_addr_t sram_addr,
  inout  sram_pkg::sram_data_t sram_data,
  output sram_pkg::sram_data_t rdata
);

  import sram_pkg::*;

  // registered bus driver
  logic       drive_q;
  sram_data_t wdata_q;

  // strobes and drive enable, inactive after reset
  always_ff @(posedge oe_n) begin
    if (rst) begin
      sram_ce_b <= 1'b1;
      sram_we_b <= 1'b1;
      sram_oe_b <= 1'b1;
      drive_q   <= 1'b0;
    end else begin
      sram_ce_b <= pins_next.ce_b;
      sram_we_b <= pins_next.we_b;
      sram_oe_b <= pins_next.oe_b;
      drive_q   <= pins_next.drive;
    end
  end

  // address and write data straight from flops
  always_ff @(posedge oe_n) begin
    sram_addr <= pins_next.addr;
    wdata_q   <= wdata_next;
  end

  // tri-state driver, high impedance unless writing
  assign sram_data = drive_q ? wdata_q : 'z;

  // read capture
  // oe_b rises on this same edge, so the flop still sees valid data
  always_ff @(posedge oe_n) begin
    if (capture) begin
      rdata <= sram_data;
    end
  end

endmodule

//--- sram_ctrl_fsm.sv
`timescale 1ns/100ps

module sram_ctrl_fsm (
  input  logic                 oe_n,
  input  logic                 rst,
  input  logic                 req_valid,
  input  sram_pkg::sram_req_t  req,
  input  sram_pkg::sram_cfg_t  cfg_q,
  output logic                 busy,
  output sram_pkg::sram_pins_t pins_next,
  output sram_pkg::sram_data_t wdata_next,
  output logic                 capture,
  output logic                 rsp_valid
);

  import sram_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;

  // request held for the whole access
  sram_req_t req_q;

  // remaining wait cycles of the current phase
  wait_t wait_cnt;

  logic accept;
  logic wait_done;
  logic counting;

  // one access in flight, so a strobe only counts while not busy
  assign accept = req_valid && !busy;

  assign wait_done = (wait_cnt == '0);

  // counter runs only in the two stretched phases
  assign counting = (state == rd_access) || (state == wr_pulse);

  // next state
  always_comb begin
    next_state = state;
    case (state)
      idle: begin
        if (accept) begin
          next_state = req.write ? wr_setup : rd_access;
        end
      end
      // oe_b low, chip gets read_wait+1 cycles
      rd_access: begin
        if (wait_done) begin
          next_state = rd_capture;
        end
      end
      // bus sampled by the pin stage at the end of this cycle
      rd_capture: begin
        next_state = recover;
      end
      // address and data go out before we_b falls
      wr_setup: begin
        next_state = wr_pulse;
      end
      // we_b low for write_wait+1 cycles
      wr_pulse: begin
        if (wait_done) begin
          next_state = wr_hold;
        end
      end
      // we_b back up, address and data still held
      wr_hold: begin
        next_state = recover;
      end
      // all pins inactive for one cycle
      recover: begin
        next_state = idle;
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

  // state, busy level and response strobe
  always_ff @(posedge oe_n) begin
    if (rst) begin
      state     <= idle;
      busy      <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      state <= next_state;
      // response one cycle after recover, reads only
      rsp_valid <= (state == recover) && !req_q.write;
      // busy ends one cycle after idle is reached,
      // when the recover values have reached the pins
      if (accept) begin
        busy <= 1'b1;
      end else if (state == idle) begin
        busy <= 1'b0;
      end
    end
  end

  // wait counter
  // loaded with the wait of the request direction on acceptance
  always_ff @(posedge oe_n) begin
    if (rst) begin
      wait_cnt <= '0;
    end else if (accept) begin
      wait_cnt <= req.write ? cfg_q.write_wait : cfg_q.read_wait;
    end else if (counting && !wait_done) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  // request payload
  always_ff @(posedge oe_n) begin
    if (accept) begin
      req_q <= req;
    end
  end

  // pin values for the next cycle
  // address always from the held request, so it only moves while idle
  // oe_b and we_b are never low together, drive stays off in reads
  always_comb begin
    pins_next.ce_b  = 1'b1;
    pins_next.we_b  = 1'b1;
    pins_next.oe_b  = 1'b1;
    pins_next.addr  = req_q.addr;
    pins_next.drive = 1'b0;
    case (state)
      rd_access: begin
        pins_next.ce_b = 1'b0;
        pins_next.oe_b = 1'b0;
      end
      wr_setup, wr_hold: begin
        pins_next.ce_b  = 1'b0;
        pins_next.drive = 1'b1;
      end
      wr_pulse: begin
        pins_next.ce_b  = 1'b0;
        pins_next.we_b  = 1'b0;
        pins_next.drive = 1'b1;
      end
      default: begin
        pins_next.ce_b = 1'b1;
      end
    endcase
  end

  // write data held with the request
  assign wdata_next = req_q.wdata;

  // pin stage samples the bus on the edge ending rd_capture
  assign capture = (state == rd_capture);

endmodule

//--- sram_cfg_regs.sv
`timescale 1ns/100ps

module sram_cfg_regs (
  input  logic                oe_n,
  input  logic                rst,
  input  logic                cfg_wr,
  input  sram_pkg::sram_cfg_t cfg,
  output sram_pkg::sram_cfg_t cfg_q
);

  import sram_pkg::*;

  // written values after the lower limit
  wait_t read_wait_in;
  wait_t write_wait_in;

  // raise a zero wait to the minimum
  function automatic wait_t clamp_wait(input wait_t value);
    wait_t result;
    result = value;
    if (value < min_wait) begin
      result = min_wait;
    end
    return result;
  endfunction

  always_comb begin
    read_wait_in  = clamp_wait(cfg.read_wait);
    write_wait_in = clamp_wait(cfg.write_wait);
  end

  // held configuration
  // new values only matter at the next accepted request,
  // the controller copies the wait into its counter on acceptance
  always_ff @(posedge oe_n) begin
    if (rst) begin
      cfg_q.read_wait  <= read_wait_rst;
      cfg_q.write_wait <= write_wait_rst;
    end else if (cfg_wr) begin
      cfg_q.read_wait  <= read_wait_in;
      cfg_q.write_wait <= write_wait_in;
    end
  end

endmodule

//--- sram_pkg.sv
package sram_pkg;

  // widths of the chip interface
  localparam int sram_addr_w = 10;
  localparam int sram_data_w = 16;

  // wait-state counter width
  localparam int wait_w = 4;

  // word address on the chip pins
  typedef logic [sram_addr_w-1:0] sram_addr_t;

  // one data word on the bidirectional bus
  typedef logic [sram_data_w-1:0] sram_data_t;

  // number of extra cycles the chip gets for an access
  typedef logic [wait_w-1:0] wait_t;

  // single access, write flag selects the direction
  typedef struct packed {
    logic       write;
    sram_addr_t addr;
    sram_data_t wdata;
  } sram_req_t;

  // wait states, separate for reads and writes
  typedef struct packed {
    wait_t read_wait;
    wait_t write_wait;
  } sram_cfg_t;

  // pin values the controller asks for, registered in the pin stage
  // drive enables the data bus output
  typedef struct packed {
    logic       ce_b;
    logic       we_b;
    logic       oe_b;
    sram_addr_t addr;
    logic       drive;
  } sram_pins_t;

  // controller sequence states
  typedef enum logic [2:0] {
    idle,
    rd_access,
    rd_capture,
    wr_setup,
    wr_pulse,
    wr_hold,
    recover
  } ctrl_state_t;

  // wait values after reset
  localparam wait_t read_wait_rst  = 4'd2;
  localparam wait_t write_wait_rst = 4'd2;

  // smallest wait the configuration accepts
  // keeps two cycles of read access time
  localparam wait_t min_wait = 4'd1;

endpackage
